// File: rtl/dspDecode_defines.svh
`ifndef DSPDECODE_DEFINES_SVH
`define DSPDECODE_DEFINES_SVH

// ============================================================
// Widths
// ============================================================
`define DSP_INSTR_W     24
`define DSP_NUM_DREG    16
`define DSP_REG_CODE_W  4
`define DSP_AMF_W       5

// ============================================================
// Opcode prefixes, compared against the top of the IR
// ============================================================
`define OPC_DUAL_READ     3'b101
`define OPC_DM_WRITE_IMM  2'b11
`define OPC_DIRECT_MOVE   3'b011
`define OPC_COMPUTE_DM    3'b100
`define OPC_COMPUTE_PM    4'b0100
`define OPC_LOAD_IMM      4'b0101
`define OPC_COMPUTE_MOVE  4'b0011
`define OPC_COMPUTE       5'b00100
`define OPC_SHIFT_DM      8'b00010001
`define OPC_SHIFT_PM      7'b0001001
`define OPC_SHIFT_IMM     8'b00010000
`define OPC_SHIFT_MOVE    8'b00001111
`define OPC_COND_SHIFT    8'b00001101

// Data register codes
`define REG_AX0  4'd0
`define REG_MX0  4'd2
`define REG_MX1  4'd3
`define REG_AY0  4'd4
`define REG_MY0  4'd6
`define REG_MY1  4'd7
`define REG_AR   4'd10
`define REG_MR0  4'd11
`define REG_MR1  4'd12
`define REG_MR2  4'd13
`define REG_SR0  4'd14
`define REG_SR1  4'd15

`endif

// File: rtl/dspDecodePkg.sv
`include "dspDecode_defines.svh"

package dspDecodePkg;

  typedef logic [`DSP_INSTR_W-1:0]    instrWord;
  typedef logic [`DSP_REG_CODE_W-1:0] regCode;
  typedef logic [`DSP_NUM_DREG-1:0]   regOneHot;   // Indexed by regCode

  typedef struct packed {
    logic dualRead;
    logic dmWriteImm;
    logic directMove;
    logic computeDm;
    logic computePm;
    logic loadImm;
    logic computeMove;
    logic compute;
    logic shiftDm;
    logic shiftPm;
    logic shiftMove;
    logic shiftImm;
    logic condShift;
  } instrClass;

  // One-hot multiplier operand selects
  typedef struct packed {
    logic xMX0;
    logic xMX1;
    logic xAR;
    logic xMR0;
    logic xMR1;
    logic xMR2;
    logic xSR0;
    logic xSR1;
    logic yMY0;
    logic yMY1;
    logic yMF;
    logic yZero;
  } macSrc;

  typedef struct packed {
    logic     aluOp;
    logic     macOp;
    logic     shtOp;
    logic     updAR;
    logic     updAF;
    logic     updMR;
    logic     updMF;
    logic     updSR;
    logic     useCond;
    logic     pRead;
    logic     pWrite;
    logic     dRead;
    logic     dWrite;
    regOneHot mtReg;
    regOneHot mfReg;
  } decodeCtl;

  typedef struct packed {
    logic updAR;
    logic updAF;
    logic updMR;
    logic updMF;
    logic updSR0;
    logic updSR1;
    logic mtValid;
    logic mfValid;
  } execStrobes;

  typedef struct packed {
    logic xByp;
    logic yByp;
    logic rByp;
  } bypassCtl;

endpackage

// File: rtl/instrClassDecode.sv
`include "dspDecode_defines.svh"

module instrClassDecode
  import dspDecodePkg::*;
(
  input  instrWord  ir,
  output instrClass cls
);

  // ============================================================
  // Prefix match, longest prefixes are shift group
  // ============================================================
  always_comb begin
    cls = '0;

    // Memory and move classes
    cls.dualRead    = (ir[23:21] == `OPC_DUAL_READ);
    cls.dmWriteImm  = (ir[23:22] == `OPC_DM_WRITE_IMM);
    cls.directMove  = (ir[23:21] == `OPC_DIRECT_MOVE);
    cls.loadImm     = (ir[23:20] == `OPC_LOAD_IMM);

    // Compute classes
    cls.computeDm   = (ir[23:21] == `OPC_COMPUTE_DM);
    cls.computePm   = (ir[23:20] == `OPC_COMPUTE_PM);
    cls.computeMove = (ir[23:20] == `OPC_COMPUTE_MOVE);
    cls.compute     = (ir[23:19] == `OPC_COMPUTE);     // Conditional ALU/MAC

    // Shifter classes
    cls.shiftDm     = (ir[23:16] == `OPC_SHIFT_DM);
    cls.shiftPm     = (ir[23:17] == `OPC_SHIFT_PM);
    cls.shiftImm    = (ir[23:16] == `OPC_SHIFT_IMM);
    cls.shiftMove   = (ir[23:16] == `OPC_SHIFT_MOVE);
    cls.condShift   = (ir[23:16] == `OPC_COND_SHIFT);
  end

endmodule

// File: rtl/regMoveDecode.sv
`include "dspDecode_defines.svh"

module regMoveDecode
  import dspDecodePkg::*;
(
  input  instrWord  ir,
  input  instrClass cls,
  output regOneHot  mtReg,
  output regOneHot  mfReg,
  output macSrc     mac
);

  logic   mtValid;
  logic   mfValid;
  logic   squ;
  regCode dstCode;
  regCode srcCode;
  regCode xDst;
  regCode yDst;

  // ============================================================
  // Register write and read selects
  // ============================================================
  assign mtValid = (cls.directMove && !ir[20] && (ir[19:18] == 2'b00)) ||
                   cls.loadImm || cls.computeMove || cls.shiftMove ||
                   ((cls.computeDm || cls.computePm) && !ir[19]) ||
                   ((cls.shiftDm || cls.shiftPm) && !ir[15]);

  assign mfValid = (cls.directMove && ir[20]) ||
                   cls.computeMove || cls.shiftMove ||
                   ((cls.computeDm || cls.computePm) && ir[19]) ||
                   ((cls.shiftDm || cls.shiftPm) && ir[15]);

  assign dstCode = (cls.directMove || cls.loadImm) ? ir[3:0] : ir[7:4];
  assign srcCode = (cls.directMove || cls.computeMove || cls.shiftMove) ? ir[3:0] : ir[7:4];

  // Dual read destinations
  assign xDst = `REG_AX0 + {2'b00, ir[19:18]};   // AX0 AX1 MX0 MX1
  assign yDst = `REG_AY0 + {2'b00, ir[21:20]};   // AY0 AY1 MY0 MY1

  always_comb begin
    mtReg = '0;
    if (mtValid) mtReg[dstCode] = 1'b1;
    if (cls.dualRead) begin
      mtReg[xDst] = 1'b1;
      mtReg[yDst] = 1'b1;
    end
  end

  always_comb begin
    mfReg = '0;
    if (mfValid) mfReg[srcCode] = 1'b1;
  end

  // ============================================================
  // Multiplier operand selects
  // ============================================================
  assign squ = cls.compute && ir[4];

  always_comb begin
    mac = '0;
    case (ir[10:8])
      3'd0: mac.xMX0 = 1'b1;
      3'd1: mac.xMX1 = 1'b1;
      3'd2: mac.xAR  = 1'b1;
      3'd3: mac.xMR0 = 1'b1;
      3'd4: mac.xMR1 = 1'b1;
      3'd5: mac.xMR2 = 1'b1;
      3'd6: mac.xSR0 = 1'b1;
      3'd7: mac.xSR1 = 1'b1;
    endcase
    // When squaring y is the same x-set register, so the y set stays clear
    if (!squ) begin
      case (ir[12:11])
        2'd0: mac.yMY0  = 1'b1;
        2'd1: mac.yMY1  = 1'b1;
        2'd2: mac.yMF   = 1'b1;
        2'd3: mac.yZero = 1'b1;
      endcase
    end
  end

endmodule

// File: rtl/computeDecode.sv
`include "dspDecode_defines.svh"

module computeDecode
  import dspDecodePkg::*;
(
  input  instrWord  ir,
  input  instrClass cls,
  input  regOneHot  mtReg,
  input  regOneHot  mfReg,
  output decodeCtl  ctl,
  output logic      macOp
);

  logic [`DSP_AMF_W-1:0] amf;
  logic                  cmpCls;
  logic                  toMain;    // AR/MR rather than AF/MF
  logic                  aluOp;

  assign amf    = ir[17:13];
  assign cmpCls = cls.dualRead || cls.computeDm || cls.computePm ||
                  cls.computeMove || cls.compute;
  assign toMain = !ir[18] || cls.dualRead;

  assign aluOp  = cmpCls && amf[4];
  assign macOp  = cmpCls && !amf[4] && (|amf[3:0]);   // AMF 0 is a NOP

  // ============================================================
  // Control word
  // ============================================================
  always_comb begin
    ctl = '0;

    ctl.aluOp   = aluOp;
    ctl.macOp   = macOp;
    ctl.shtOp   = cls.shiftDm || cls.shiftPm || cls.shiftMove ||
                  cls.shiftImm || cls.condShift;
    ctl.updAR   = aluOp && toMain;
    ctl.updAF   = aluOp && !toMain;
    ctl.updMR   = macOp && toMain;
    ctl.updMF   = macOp && !toMain;
    ctl.updSR   = ctl.shtOp && (ir[14:13] != 2'b11);   // SF 11xx leaves SR alone
    ctl.useCond = cls.compute || cls.condShift;

    // Memory commands
    ctl.pRead   = cls.dualRead ||
                  (cls.computePm && !ir[19]) ||
                  (cls.shiftPm && !ir[15]);
    ctl.pWrite  = (cls.computePm && ir[19]) ||
                  (cls.shiftPm && ir[15]);
    ctl.dRead   = cls.dualRead ||
                  (cls.directMove && !ir[20]) ||
                  (cls.computeDm && !ir[19]) ||
                  (cls.shiftDm && !ir[15]);
    ctl.dWrite  = cls.dmWriteImm ||
                  (cls.directMove && ir[20]) ||
                  (cls.computeDm && ir[19]) ||
                  (cls.shiftDm && ir[15]);

    ctl.mtReg   = mtReg;
    ctl.mfReg   = mfReg;
  end

endmodule

// File: rtl/execStage.sv
`include "dspDecode_defines.svh"

module execStage
  import dspDecodePkg::*;
(
  input  logic       DSPCLK,
  input  logic       PPclr,
  input  instrWord   cmRd,
  input  logic       goD,
  input  logic       goE,
  input  logic       goC,
  input  logic       prdErr,
  input  logic       cTrue,
  input  decodeCtl   ctl,
  output instrWord   ir,
  output decodeCtl   ctlE,
  output logic       exEn,
  output logic       exEnc,
  output execStrobes strobes
);

  logic     prdErrC;
  logic     dummyE;

  // ============================================================
  // Instruction pipeline
  // ============================================================
  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      ir <= '0;
    end else if (goD) begin
      ir <= cmRd;
    end
  end

  // E stage picks up the old decode when goD and goE coincide
  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      ctlE <= '0;
    end else if (goE) begin
      ctlE <= ctl;
    end
  end

  // ============================================================
  // Dummy slots after a program read error
  // ============================================================
  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      prdErrC <= 1'b0;
    end else if (goC) begin
      prdErrC <= prdErr;
    end
  end

  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      dummyE <= 1'b0;
    end else if (goE) begin
      dummyE <= prdErr || prdErrC;     // Covers up to two slots
    end
  end

  // ============================================================
  // Execute enables and gated strobes
  // ============================================================
  assign exEn  = !dummyE;
  assign exEnc = exEn && (!ctlE.useCond || cTrue);

  always_comb begin
    strobes = '0;
    strobes.updMR   = ctlE.updMR && exEnc;
    strobes.updMF   = ctlE.updMF && exEnc;
    strobes.updAF   = ctlE.updAF && exEnc;
    strobes.updAR   = (ctlE.updAR && exEnc) || (ctlE.mtReg[`REG_AR] && exEn);
    strobes.updSR0  = (ctlE.updSR && exEnc) || (ctlE.mtReg[`REG_SR0] && exEn);
    strobes.updSR1  = (ctlE.updSR && exEnc) || (ctlE.mtReg[`REG_SR1] && exEn);
    strobes.mtValid = (|ctlE.mtReg) && exEn;   // Moves ignore the condition
    strobes.mfValid = (|ctlE.mfReg) && exEn;
  end

endmodule

// File: rtl/macHazard.sv
`include "dspDecode_defines.svh"

module macHazard
  import dspDecodePkg::*;
(
  input  logic     DSPCLK,
  input  logic     PPclr,
  input  logic     goE,
  input  logic     macOp,
  input  macSrc    mac,
  input  decodeCtl ctlE,
  input  logic     exEn,
  input  logic     exEnc,
  output bypassCtl byp,
  output logic     macDep
);

  logic savMR0;
  logic savMR1;
  logic savMR2;
  logic updARg;
  logic updSR0g;
  logic updSR1g;
  logic updMRg;
  logic updMFg;
  logic xIsMR;
  logic depR;

  // ============================================================
  // E stage writers
  // ============================================================
  assign savMR0  = ctlE.mtReg[`REG_MR0] && exEn;
  assign savMR1  = ctlE.mtReg[`REG_MR1] && exEn;
  assign savMR2  = (ctlE.mtReg[`REG_MR1] || ctlE.mtReg[`REG_MR2]) && exEn;   // MR1 sign-extends
  assign updARg  = (ctlE.updAR && exEnc) || (ctlE.mtReg[`REG_AR] && exEn);
  assign updSR0g = (ctlE.updSR && exEnc) || (ctlE.mtReg[`REG_SR0] && exEn);
  assign updSR1g = (ctlE.updSR && exEnc) || (ctlE.mtReg[`REG_SR1] && exEn);
  assign updMRg  = ctlE.updMR && exEnc;
  assign updMFg  = ctlE.updMF && exEnc;

  // Squared y mirrors x, so the x set covers both operands
  assign xIsMR = mac.xMR0 || mac.xMR1 || mac.xMR2;

  // ============================================================
  // Bypass selects
  // ============================================================
  always_comb begin
    byp = '0;
    byp.xByp = macOp && ((ctlE.mtReg[`REG_MX0] && exEn && mac.xMX0) ||
                         (ctlE.mtReg[`REG_MX1] && exEn && mac.xMX1));
    byp.yByp = macOp && ((ctlE.mtReg[`REG_MY0] && exEn && mac.yMY0) ||
                         (ctlE.mtReg[`REG_MY1] && exEn && mac.yMY1));
    byp.rByp = (savMR0 && mac.xMR0) || (savMR1 && mac.xMR1) ||
               (savMR2 && mac.xMR2) || (updARg && mac.xAR) ||
               (updSR0g && mac.xSR0) || (updSR1g && mac.xSR1);
  end

  // MAC result still in flight for the next operand read
  assign depR = macOp && ((updMFg && mac.yMF) || (updMRg && xIsMR));

  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      macDep <= 1'b0;
    end else if (goE) begin
      macDep <= depR;
    end
  end

endmodule

// File: rtl/dspDecodeTop.sv
module dspDecodeTop
  import dspDecodePkg::*;
(
  input  logic       DSPCLK,
  input  logic       PPclr,
  input  instrWord   cmRd,
  input  logic       goD,
  input  logic       goE,
  input  logic       goC,
  input  logic       prdErr,
  input  logic       cTrue,
  output instrWord   ir,
  output decodeCtl   ctlE,
  output logic       exEn,
  output logic       exEnc,
  output execStrobes strobes,
  output bypassCtl   byp,
  output logic       macDep
);

  instrClass cls;
  regOneHot  mtReg;
  regOneHot  mfReg;
  macSrc     mac;
  decodeCtl  ctl;        // R stage decode
  logic      macOp;

  // ============================================================
  // R stage decode
  // ============================================================
  instrClassDecode uClass (
    .ir  (ir),
    .cls (cls)
  );

  regMoveDecode uMove (
    .ir    (ir),
    .cls   (cls),
    .mtReg (mtReg),
    .mfReg (mfReg),
    .mac   (mac)
  );

  computeDecode uCompute (
    .ir    (ir),
    .cls   (cls),
    .mtReg (mtReg),
    .mfReg (mfReg),
    .ctl   (ctl),
    .macOp (macOp)
  );

  // ============================================================
  // Pipeline registers and hazards
  // ============================================================
  execStage uExec (
    .DSPCLK  (DSPCLK),
    .PPclr   (PPclr),
    .cmRd    (cmRd),
    .goD     (goD),
    .goE     (goE),
    .goC     (goC),
    .prdErr  (prdErr),
    .cTrue   (cTrue),
    .ctl     (ctl),
    .ir      (ir),
    .ctlE    (ctlE),
    .exEn    (exEn),
    .exEnc   (exEnc),
    .strobes (strobes)
  );

  macHazard uHazard (
    .DSPCLK (DSPCLK),
    .PPclr  (PPclr),
    .goE    (goE),
    .macOp  (macOp),
    .mac    (mac),
    .ctlE   (ctlE),
    .exEn   (exEn),
    .exEnc  (exEnc),
    .byp    (byp),
    .macDep (macDep)
  );

endmodule

// File: tb/dspDecodeTb.sv
module dspDecodeTb
  import dspDecodePkg::*;
();

  // One table row per pipeline step; expected E stage values belong to the previous row
  typedef struct packed {
    instrWord   cmRd;
    logic       prdErr;
    logic       cTrue;
    decodeCtl   ctl;
    logic       exEn;
    logic       exEnc;
    execStrobes stb;
    bypassCtl   byp;
    logic       macDep;
  } stepRow;

  logic       DSPCLK;
  logic       PPclr;
  instrWord   cmRd;
  logic       goD;
  logic       goE;
  logic       goC;
  logic       prdErr;
  logic       cTrue;
  instrWord   ir;
  decodeCtl   ctlE;
  logic       exEn;
  logic       exEnc;
  execStrobes strobes;
  bypassCtl   byp;
  logic       macDep;

  stepRow rows[$];
  int     curRow;
  int     cycleCount = 0;
  int     cycleLimit;

  dspDecodeTop UUT (
    .DSPCLK  (DSPCLK),
    .PPclr   (PPclr),
    .cmRd    (cmRd),
    .goD     (goD),
    .goE     (goE),
    .goC     (goC),
    .prdErr  (prdErr),
    .cTrue   (cTrue),
    .ir      (ir),
    .ctlE    (ctlE),
    .exEn    (exEn),
    .exEnc   (exEnc),
    .strobes (strobes),
    .byp     (byp),
    .macDep  (macDep)
  );

  initial begin
    DSPCLK = 1'b0;
    forever #2 DSPCLK = ~DSPCLK;
  end

  // ============================================================
  // Error handling and compare tasks
  // ============================================================
  task automatic abortRun();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkWord(input string name, input instrWord got, input instrWord exp);
    if (got !== exp) begin
      $display("Mismatch %s (row %0d): got 0x%h, expected 0x%h", name, curRow, got, exp);
      abortRun();
    end
  endtask

  task automatic checkCtl(input string name, input decodeCtl got, input decodeCtl exp);
    if (got !== exp) begin
      $display("Mismatch %s (row %0d): got 0x%h, expected 0x%h", name, curRow, got, exp);
      abortRun();
    end
  endtask

  task automatic checkStrobes(input string name, input execStrobes got, input execStrobes exp);
    if (got !== exp) begin
      $display("Mismatch %s (row %0d): got 0x%h, expected 0x%h", name, curRow, got, exp);
      abortRun();
    end
  endtask

  task automatic checkByp(input string name, input bypassCtl got, input bypassCtl exp);
    if (got !== exp) begin
      $display("Mismatch %s (row %0d): got 0x%h, expected 0x%h", name, curRow, got, exp);
      abortRun();
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s (row %0d): got 0x%h, expected 0x%h", name, curRow, got, exp);
      abortRun();
    end
  endtask

  // ============================================================
  // Stimulus table
  // ============================================================
  // flags: aluOp macOp shtOp _ updAR updAF updMR updMF updSR _ useCond _ pRd pWr dRd dWr
  // stb:   updAR updAF updMR updMF _ updSR0 updSR1 _ mtValid mfValid
  task automatic addRow(input instrWord word, input logic err, input logic cond,
                        input logic [12:0] flags, input regOneHot mt, input regOneHot mf,
                        input logic en, input logic enc, input execStrobes stb,
                        input bypassCtl bp, input logic dep);
    stepRow r;
    r.cmRd   = word;
    r.prdErr = err;
    r.cTrue  = cond;
    r.ctl    = {flags, mt, mf};
    r.exEn   = en;
    r.exEnc  = enc;
    r.stb    = stb;
    r.byp    = bp;
    r.macDep = dep;
    rows.push_back(r);
  endtask

  task automatic buildTable();
    addRow(24'h600001, 1'b0, 1'b1, 13'b000_00000_0_0000, 16'h0000, 16'h0000,   // DM read to AX1
           1'b1, 1'b1, 8'b0000_00_00, 3'b000, 1'b0);
    addRow(24'h700009, 1'b0, 1'b1, 13'b000_00000_0_0010, 16'h0002, 16'h0000,   // DM write from SE
           1'b1, 1'b1, 8'b0000_00_10, 3'b000, 1'b0);
    addRow(24'h500007, 1'b0, 1'b1, 13'b000_00000_0_0001, 16'h0000, 16'h0200,   // Load MY1
           1'b1, 1'b1, 8'b0000_00_01, 3'b000, 1'b0);
    addRow(24'hC00000, 1'b0, 1'b1, 13'b000_00000_0_0000, 16'h0080, 16'h0000,   // DM write immediate
           1'b1, 1'b1, 8'b0000_00_10, 3'b000, 1'b0);
    addRow(24'hAA6000, 1'b0, 1'b1, 13'b000_00000_0_0001, 16'h0000, 16'h0000,   // Dual read MX0 MY0
           1'b1, 1'b1, 8'b0000_00_00, 3'b000, 1'b0);
    addRow(24'h8420E0, 1'b0, 1'b1, 13'b100_10000_0_1010, 16'h0044, 16'h0000,   // MAC to MF, SR0 from DM
           1'b1, 1'b1, 8'b1000_00_10, 3'b110, 1'b0);
    addRow(24'h4E00D0, 1'b0, 1'b1, 13'b010_00010_0_0010, 16'h4000, 16'h0000,   // ALU to AF, MR2 to PM
           1'b1, 1'b1, 8'b0001_10_10, 3'b000, 1'b0);
    addRow(24'h30003F, 1'b0, 1'b1, 13'b100_01000_0_0100, 16'h0000, 16'h2000,   // Move MX1 from SR1
           1'b1, 1'b1, 8'b0100_00_01, 3'b000, 1'b0);
    addRow(24'h112040, 1'b0, 1'b1, 13'b000_00000_0_0000, 16'h0008, 16'h8000,   // Shift, AY0 from DM
           1'b1, 1'b1, 8'b0000_00_11, 3'b000, 1'b0);
    addRow(24'h12E000, 1'b0, 1'b1, 13'b001_00001_0_0010, 16'h0010, 16'h0000,   // Shift, AX0 to PM
           1'b1, 1'b1, 8'b0000_11_10, 3'b000, 1'b0);
    addRow(24'h100000, 1'b0, 1'b1, 13'b001_00000_0_0100, 16'h0000, 16'h0001,   // Shift immediate
           1'b1, 1'b1, 8'b0000_00_01, 3'b000, 1'b0);
    addRow(24'h0F6089, 1'b0, 1'b1, 13'b001_00001_0_0000, 16'h0000, 16'h0000,   // Shift, SI from SE
           1'b1, 1'b1, 8'b0000_11_00, 3'b000, 1'b0);
    addRow(24'h0D0000, 1'b0, 1'b1, 13'b001_00000_0_0000, 16'h0100, 16'h0200,   // Conditional shift
           1'b1, 1'b1, 8'b0000_00_11, 3'b000, 1'b0);
    addRow(24'h0070F0, 1'b0, 1'b0, 13'b001_00001_1_0000, 16'h0000, 16'h0000,   // Unknown word
           1'b1, 1'b0, 8'b0000_00_00, 3'b000, 1'b0);
    addRow(24'h204000, 1'b0, 1'b1, 13'b000_00000_0_0000, 16'h0000, 16'h0000,   // Conditional MAC
           1'b1, 1'b1, 8'b0000_00_00, 3'b000, 1'b0);
    addRow(24'h500002, 1'b0, 1'b0, 13'b010_00100_1_0000, 16'h0000, 16'h0000,   // Load MX0
           1'b1, 1'b0, 8'b0000_00_00, 3'b000, 1'b0);
    addRow(24'h204000, 1'b0, 1'b0, 13'b000_00000_0_0000, 16'h0004, 16'h0000,   // MAC with x MX0
           1'b1, 1'b1, 8'b0000_00_10, 3'b100, 1'b0);
    addRow(24'h100000, 1'b1, 1'b1, 13'b010_00100_1_0000, 16'h0000, 16'h0000,   // Program read error
           1'b0, 1'b0, 8'b0000_00_00, 3'b000, 1'b0);
    addRow(24'h204000, 1'b0, 1'b1, 13'b001_00001_0_0000, 16'h0000, 16'h0000,   // MAC updating MR
           1'b0, 1'b0, 8'b0000_00_00, 3'b000, 1'b0);
    addRow(24'h204400, 1'b0, 1'b1, 13'b010_00100_1_0000, 16'h0000, 16'h0000,   // MAC with x MR1
           1'b1, 1'b1, 8'b0010_00_00, 3'b000, 1'b0);
    addRow(24'h50000C, 1'b0, 1'b1, 13'b010_00100_1_0000, 16'h0000, 16'h0000,   // Load MR1
           1'b1, 1'b1, 8'b0010_00_00, 3'b000, 1'b1);
    addRow(24'h204400, 1'b0, 1'b1, 13'b000_00000_0_0000, 16'h1000, 16'h0000,   // MAC with x MR1
           1'b1, 1'b1, 8'b0000_00_10, 3'b001, 1'b0);
    addRow(24'h0070F0, 1'b0, 1'b1, 13'b010_00100_1_0000, 16'h0000, 16'h0000,   // Drain
           1'b1, 1'b1, 8'b0010_00_00, 3'b000, 1'b0);
  endtask

  // One step with all stage strobes, then check after the edge
  task automatic applyRow(input stepRow r);
    @(negedge DSPCLK);
    cmRd   = r.cmRd;
    prdErr = r.prdErr;
    cTrue  = r.cTrue;
    goD    = 1'b1;
    goE    = 1'b1;
    goC    = 1'b1;
    @(negedge DSPCLK);
    checkWord("ir", ir, r.cmRd);
    checkCtl("ctlE", ctlE, r.ctl);
    checkBit("exEn", exEn, r.exEn);
    checkBit("exEnc", exEnc, r.exEnc);
    checkStrobes("strobes", strobes, r.stb);
    checkByp("byp", byp, r.byp);
    checkBit("macDep", macDep, r.macDep);
    goD = 1'b0;
    goE = 1'b0;
    goC = 1'b0;
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    PPclr  = 1'b1;
    cmRd   = '0;
    goD    = 1'b0;
    goE    = 1'b0;
    goC    = 1'b0;
    prdErr = 1'b0;
    cTrue  = 1'b0;
    curRow = -1;                             // Reset check
    buildTable();
    cycleLimit = 4 * rows.size() + 40;

    repeat (8) @(posedge DSPCLK);
    @(negedge DSPCLK);
    PPclr = 1'b0;
    @(negedge DSPCLK);
    checkCtl("ctlE", ctlE, '0);
    checkStrobes("strobes", strobes, '0);
    checkByp("byp", byp, '0);
    checkBit("macDep", macDep, 1'b0);
    checkBit("exEn", exEn, 1'b1);

    foreach (rows[i]) begin
      curRow = i;
      applyRow(rows[i]);
    end

    $display("** PASS **");
    $finish;
  end

  always @(posedge DSPCLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      abortRun();
    end
  end

endmodule

// File: dspDecode.f
+incdir+rtl
rtl/dspDecodePkg.sv
rtl/instrClassDecode.sv
rtl/regMoveDecode.sv
rtl/computeDecode.sv
rtl/execStage.sv
rtl/macHazard.sv
rtl/dspDecodeTop.sv
tb/dspDecodeTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module dspDecodeTb -f dspDecode.f -o dspDecodeSim || exit 1
out=$(./obj_dir/dspDecodeSim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '** PASS **' && echo "RESULT: passed" || { echo "RESULT: failed"; exit 1; }
